// ==== list.f ====
src/wb_ic_pkg.sv
src/wb_if.sv
src/wb_port_decode.sv
src/wb_rr_arbiter.sv
src/wb_xbar_route.sv
src/wb_decode_err_target.sv
src/wb_interconnect_2x4.sv
test/tb_wb_interconnect.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_wb_interconnect \
	-f list.f -o sim_tb
./obj_dir/sim_tb

// ==== src/wb_decode_err_target.sv ====
// Decode-fail target answering every unmapped cycle with a one-cycle error
`timescale 1ns/1ps

module wb_decode_err_target (
	input logic clk,
	input logic rstn,
	wb_if.target bus_i
);

	// Error pulse
	logic err_q;
	// Cycle already answered, wait for stb to drop
	logic done_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			// Fire once, one clock after the strobe is seen
			err_q <= bus_i.cyc && bus_i.stb && !err_q && !done_q;
			if (err_q) begin
				done_q <= 1'b1;
			end else if (!bus_i.stb) begin
				done_q <= 1'b0;
			end
		end
	end

	// Never acks, no read data
	assign bus_i.ack = 1'b0;
	assign bus_i.err = err_q;
	assign bus_i.dat_r = '0;

endmodule

// ==== src/wb_ic_pkg.sv ====
// Interconnect widths, counts, vector typedefs and FSM state enums
package wb_ic_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int SEL_W = DATA_W / 8;

	// Port counts
	localparam int N_MASTERS = 2;
	localparam int N_SLAVES = 4;
	// Real slaves plus the decode-fail target
	localparam int N_TARGETS = N_SLAVES + 1;
	// Decode-fail target sits right after the last slave
	localparam int ERR_TARGET = N_SLAVES;

	// Bus fields
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [SEL_W-1:0] sel_t;

	// Index types
	typedef logic [2:0] target_id_t;
	typedef logic [0:0] master_id_t;

	// One address per slave, used for both bases and limits
	typedef addr_t [N_SLAVES-1:0] addr_map_t;

	// Per-master routing FSM
	typedef enum logic {PORT_IDLE, PORT_BUSY} port_state_e;

	// Per-target arbiter FSM
	typedef enum logic {ARB_IDLE, ARB_HOLD} arb_state_e;

endpackage

// ==== src/wb_if.sv ====
// Wishbone classic bus interface with initiator, target and monitor modports
`timescale 1ns/1ps

interface wb_if;

	// Request side
	logic cyc;
	logic stb;
	logic we;
	wb_ic_pkg::addr_t adr;
	wb_ic_pkg::sel_t sel;
	wb_ic_pkg::data_t dat_w;

	// Response side
	wb_ic_pkg::data_t dat_r;
	logic ack;
	logic err;

	// Bus master view
	modport initiator (output cyc, stb, we, adr, sel, dat_w, input dat_r, ack, err);

	// Bus slave view
	modport target (input cyc, stb, we, adr, sel, dat_w, output dat_r, ack, err);

	// Observe only
	modport monitor (input cyc, stb, we, adr, sel, dat_w, dat_r, ack, err);

endinterface

// ==== src/wb_interconnect_2x4.sv ====
// Two-master four-slave Wishbone interconnect top level with address map
`timescale 1ns/1ps

module wb_interconnect_2x4 #(
	// Slave k owns k*0x1000 up to k*0x1000+0xFFF
	parameter wb_ic_pkg::addr_map_t SLAVE_BASE = {32'h0000_3000, 32'h0000_2000,
		32'h0000_1000, 32'h0000_0000},
	parameter wb_ic_pkg::addr_map_t SLAVE_LIMIT = {32'h0000_3FFF, 32'h0000_2FFF,
		32'h0000_1FFF, 32'h0000_0FFF}
) (
	input logic clk,
	input logic rstn,

	// Master side
	input logic [wb_ic_pkg::N_MASTERS-1:0] m_cyc_i,
	input logic [wb_ic_pkg::N_MASTERS-1:0] m_stb_i,
	input logic [wb_ic_pkg::N_MASTERS-1:0] m_we_i,
	input wb_ic_pkg::addr_t [wb_ic_pkg::N_MASTERS-1:0] m_adr_i,
	input wb_ic_pkg::sel_t [wb_ic_pkg::N_MASTERS-1:0] m_sel_i,
	input wb_ic_pkg::data_t [wb_ic_pkg::N_MASTERS-1:0] m_dat_w_i,
	output wb_ic_pkg::data_t [wb_ic_pkg::N_MASTERS-1:0] m_dat_r_o,
	output logic [wb_ic_pkg::N_MASTERS-1:0] m_ack_o,
	output logic [wb_ic_pkg::N_MASTERS-1:0] m_err_o,

	// Slave side
	output logic [wb_ic_pkg::N_SLAVES-1:0] s_cyc_o,
	output logic [wb_ic_pkg::N_SLAVES-1:0] s_stb_o,
	output logic [wb_ic_pkg::N_SLAVES-1:0] s_we_o,
	output wb_ic_pkg::addr_t [wb_ic_pkg::N_SLAVES-1:0] s_adr_o,
	output wb_ic_pkg::sel_t [wb_ic_pkg::N_SLAVES-1:0] s_sel_o,
	output wb_ic_pkg::data_t [wb_ic_pkg::N_SLAVES-1:0] s_dat_w_o,
	input wb_ic_pkg::data_t [wb_ic_pkg::N_SLAVES-1:0] s_dat_r_i,
	input logic [wb_ic_pkg::N_SLAVES-1:0] s_ack_i,
	input logic [wb_ic_pkg::N_SLAVES-1:0] s_err_i
);

	// Internal buses, last target entry is the decode-fail target
	wb_if m_bus [wb_ic_pkg::N_MASTERS] ();
	wb_if t_bus [wb_ic_pkg::N_TARGETS] ();

	// Decode results per master
	wb_ic_pkg::target_id_t port_target [wb_ic_pkg::N_MASTERS];
	logic [wb_ic_pkg::N_MASTERS-1:0] port_sel;

	// Arbitration per target
	logic [wb_ic_pkg::N_MASTERS-1:0] tgt_req [wb_ic_pkg::N_TARGETS];
	logic [wb_ic_pkg::N_TARGETS-1:0] tgt_gnt;
	wb_ic_pkg::master_id_t tgt_gnt_id [wb_ic_pkg::N_TARGETS];

	for (genvar m = 0; m < wb_ic_pkg::N_MASTERS; m++) begin : g_master
		assign m_bus[m].cyc = m_cyc_i[m];
		assign m_bus[m].stb = m_stb_i[m];
		assign m_bus[m].we = m_we_i[m];
		assign m_bus[m].adr = m_adr_i[m];
		assign m_bus[m].sel = m_sel_i[m];
		assign m_bus[m].dat_w = m_dat_w_i[m];
		assign m_dat_r_o[m] = m_bus[m].dat_r;
		assign m_ack_o[m] = m_bus[m].ack;
		assign m_err_o[m] = m_bus[m].err;

		wb_port_decode #(
			.SLAVE_BASE(SLAVE_BASE),
			.SLAVE_LIMIT(SLAVE_LIMIT)
		) u_decode (
			.clk(clk),
			.rstn(rstn),
			.bus_i(m_bus[m]),
			.target_o(port_target[m]),
			.selected_o(port_sel[m])
		);
	end

	for (genvar t = 0; t < wb_ic_pkg::N_TARGETS; t++) begin : g_target
		// A master requests target t while its latched route points there
		for (genvar m = 0; m < wb_ic_pkg::N_MASTERS; m++) begin : g_req
			assign tgt_req[t][m] = port_sel[m] &&
				(port_target[m] == wb_ic_pkg::target_id_t'(t));
		end

		wb_rr_arbiter #(
			.N_REQ(wb_ic_pkg::N_MASTERS)
		) u_arb (
			.clk(clk),
			.rstn(rstn),
			.req_i(tgt_req[t]),
			.gnt_o(tgt_gnt[t]),
			.gnt_id_o(tgt_gnt_id[t])
		);
	end

	wb_xbar_route u_xbar (
		.m_bus_i(m_bus),
		.t_bus_o(t_bus),
		.gnt_i(tgt_gnt),
		.gnt_id_i(tgt_gnt_id),
		.target_i(port_target),
		.selected_i(port_sel)
	);

	// Real slaves go straight out to the ports
	for (genvar s = 0; s < wb_ic_pkg::N_SLAVES; s++) begin : g_slave
		assign s_cyc_o[s] = t_bus[s].cyc;
		assign s_stb_o[s] = t_bus[s].stb;
		assign s_we_o[s] = t_bus[s].we;
		assign s_adr_o[s] = t_bus[s].adr;
		assign s_sel_o[s] = t_bus[s].sel;
		assign s_dat_w_o[s] = t_bus[s].dat_w;
		assign t_bus[s].dat_r = s_dat_r_i[s];
		assign t_bus[s].ack = s_ack_i[s];
		assign t_bus[s].err = s_err_i[s];
	end

	// Catches everything outside the map
	wb_decode_err_target u_err (
		.clk(clk),
		.rstn(rstn),
		.bus_i(t_bus[wb_ic_pkg::ERR_TARGET])
	);

endmodule

// ==== src/wb_port_decode.sv ====
// Per-master address decode FSM that latches the target index for one cycle
`timescale 1ns/1ps

module wb_port_decode #(
	parameter wb_ic_pkg::addr_map_t SLAVE_BASE = '0,
	parameter wb_ic_pkg::addr_map_t SLAVE_LIMIT = '0
) (
	input logic clk,
	input logic rstn,
	wb_if.monitor bus_i,
	output wb_ic_pkg::target_id_t target_o,
	output logic selected_o
);

	wb_ic_pkg::port_state_e state;
	wb_ic_pkg::target_id_t target_q;
	// Combinational decode of the current address
	wb_ic_pkg::target_id_t hit_id;

	// Walk the windows from the top down so the lowest index wins on overlap
	always_comb begin
		hit_id = wb_ic_pkg::target_id_t'(wb_ic_pkg::ERR_TARGET);
		for (int k = wb_ic_pkg::N_SLAVES - 1; k >= 0; k--) begin
			if (bus_i.adr >= SLAVE_BASE[k] && bus_i.adr <= SLAVE_LIMIT[k]) begin
				hit_id = wb_ic_pkg::target_id_t'(k);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= wb_ic_pkg::PORT_IDLE;
			target_q <= '0;
		end else begin
			case (state)
				wb_ic_pkg::PORT_IDLE: begin
					// New cycle starts, capture its destination
					if (bus_i.cyc && bus_i.stb) begin
						target_q <= hit_id;
						state <= wb_ic_pkg::PORT_BUSY;
					end
				end
				wb_ic_pkg::PORT_BUSY: begin
					// Completion from the routed target frees the port
					if (bus_i.ack || bus_i.err) begin
						state <= wb_ic_pkg::PORT_IDLE;
					end
				end
				default: state <= wb_ic_pkg::PORT_IDLE;
			endcase
		end
	end

	assign target_o = target_q;
	assign selected_o = (state == wb_ic_pkg::PORT_BUSY);

	// Route must not move under an outstanding cycle
	// Latched target keeps matching the address the master still holds
	a_target_stable: assert property (@(posedge clk) disable iff (!rstn)
		(state == wb_ic_pkg::PORT_BUSY && bus_i.cyc && bus_i.stb) |->
		(target_o == hit_id));

endmodule

// ==== src/wb_rr_arbiter.sv ====
// Round-robin arbiter for one target with grant hold until request release
`timescale 1ns/1ps

module wb_rr_arbiter #(
	parameter int N_REQ = 2
) (
	input logic clk,
	input logic rstn,
	input logic [N_REQ-1:0] req_i,
	output logic gnt_o,
	output wb_ic_pkg::master_id_t gnt_id_o
);

	localparam int ID_W = $clog2(N_REQ);

	wb_ic_pkg::arb_state_e state;
	// One-hot grant, zero when idle
	logic [N_REQ-1:0] gnt_q;
	// Last granted requester, doubles as the current grant id
	logic [ID_W-1:0] last_id;
	// Next winner
	logic [N_REQ-1:0] nxt_vec;
	logic [ID_W-1:0] nxt_id;
	logic found;

	// Circular search starting just above the last grant
	// Wraps to the lowest requester when nothing above is asking
	always_comb begin
		int idx;
		nxt_vec = '0;
		nxt_id = last_id;
		found = 1'b0;
		for (int k = 1; k <= N_REQ; k++) begin
			idx = (int'(last_id) + k) % N_REQ;
			if (!found && req_i[idx]) begin
				found = 1'b1;
				nxt_vec[idx] = 1'b1;
				nxt_id = ID_W'(idx);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= wb_ic_pkg::ARB_IDLE;
			gnt_q <= '0;
			// Pointer at the top so requester 0 goes first
			last_id <= ID_W'(N_REQ - 1);
		end else begin
			case (state)
				wb_ic_pkg::ARB_IDLE: begin
					if (found) begin
						gnt_q <= nxt_vec;
						last_id <= nxt_id;
						state <= wb_ic_pkg::ARB_HOLD;
					end
				end
				wb_ic_pkg::ARB_HOLD: begin
					// Owner dropped its request, free for the next round
					if ((gnt_q & req_i) == '0) begin
						gnt_q <= '0;
						state <= wb_ic_pkg::ARB_IDLE;
					end
				end
				default: state <= wb_ic_pkg::ARB_IDLE;
			endcase
		end
	end

	assign gnt_o = |gnt_q;
	assign gnt_id_o = wb_ic_pkg::master_id_t'(last_id);

	// At most one owner at any time
	a_gnt_onehot: assert property (@(posedge clk) disable iff (!rstn)
		$onehot0(gnt_q));

endmodule

// ==== src/wb_xbar_route.sv ====
// Crossbar muxing granted master requests to targets and responses back
`timescale 1ns/1ps

module wb_xbar_route (
	wb_if.target m_bus_i [wb_ic_pkg::N_MASTERS],
	wb_if.initiator t_bus_o [wb_ic_pkg::N_TARGETS],
	input logic [wb_ic_pkg::N_TARGETS-1:0] gnt_i,
	input wb_ic_pkg::master_id_t gnt_id_i [wb_ic_pkg::N_TARGETS],
	input wb_ic_pkg::target_id_t target_i [wb_ic_pkg::N_MASTERS],
	input logic [wb_ic_pkg::N_MASTERS-1:0] selected_i
);

	localparam int NM = wb_ic_pkg::N_MASTERS;
	localparam int NT = wb_ic_pkg::N_TARGETS;

	// Master requests pulled out of the interface array for indexed muxing
	logic [NM-1:0] m_cyc;
	logic [NM-1:0] m_stb;
	logic [NM-1:0] m_we;
	wb_ic_pkg::addr_t m_adr [NM];
	wb_ic_pkg::sel_t m_sel [NM];
	wb_ic_pkg::data_t m_dat_w [NM];

	// Target responses, same idea
	wb_ic_pkg::data_t t_dat_r [NT];
	logic [NT-1:0] t_ack;
	logic [NT-1:0] t_err;

	// Master currently holds the target it decoded to
	logic [NM-1:0] owned;
	logic [NM-1:0] m_ack;

	for (genvar m = 0; m < NM; m++) begin : g_master
		assign m_cyc[m] = m_bus_i[m].cyc;
		assign m_stb[m] = m_bus_i[m].stb;
		assign m_we[m] = m_bus_i[m].we;
		assign m_adr[m] = m_bus_i[m].adr;
		assign m_sel[m] = m_bus_i[m].sel;
		assign m_dat_w[m] = m_bus_i[m].dat_w;

		assign owned[m] = selected_i[m] && gnt_i[target_i[m]] &&
			(gnt_id_i[target_i[m]] == wb_ic_pkg::master_id_t'(m));

		// Response path is quiet unless this master owns the target
		assign m_ack[m] = owned[m] && t_ack[target_i[m]];
		assign m_bus_i[m].ack = m_ack[m];
		assign m_bus_i[m].err = owned[m] && t_err[target_i[m]];
		assign m_bus_i[m].dat_r = owned[m] ? t_dat_r[target_i[m]] : '0;
	end

	for (genvar t = 0; t < NT; t++) begin : g_target
		assign t_dat_r[t] = t_bus_o[t].dat_r;
		assign t_ack[t] = t_bus_o[t].ack;
		assign t_err[t] = t_bus_o[t].err;

		// Granted master drives the target, idle bus otherwise
		assign t_bus_o[t].cyc = gnt_i[t] ? m_cyc[gnt_id_i[t]] : 1'b0;
		assign t_bus_o[t].stb = gnt_i[t] ? m_stb[gnt_id_i[t]] : 1'b0;
		assign t_bus_o[t].we = gnt_i[t] ? m_we[gnt_id_i[t]] : 1'b0;
		assign t_bus_o[t].adr = gnt_i[t] ? m_adr[gnt_id_i[t]] : '0;
		assign t_bus_o[t].sel = gnt_i[t] ? m_sel[gnt_id_i[t]] : '0;
		assign t_bus_o[t].dat_w = gnt_i[t] ? m_dat_w[gnt_id_i[t]] : '0;
	end

	// One target ack lands on a single master, decode and grant must agree
	for (genvar a = 0; a < NM; a++) begin : g_chk_a
		for (genvar b = a + 1; b < NM; b++) begin : g_chk_b
			always_comb begin
				a_single_ack: assert final (!(m_ack[a] && m_ack[b] &&
					target_i[a] == target_i[b]))
					else $error("Target ack routed to two masters");
			end
		end
	end

endmodule

// ==== test/tb_wb_interconnect.sv ====
// Testbench for the 2x4 Wishbone interconnect with slave memory models and a reference memory
`timescale 1ns/1ps

module tb_wb_interconnect;

	localparam int NM = wb_ic_pkg::N_MASTERS;
	localparam int NS = wb_ic_pkg::N_SLAVES;

	logic clk;
	logic rstn;
	logic [NM-1:0] m_cyc, m_stb, m_we, m_ack, m_err;
	wb_ic_pkg::addr_t [NM-1:0] m_adr;
	wb_ic_pkg::sel_t [NM-1:0] m_sel;
	wb_ic_pkg::data_t [NM-1:0] m_dat_w, m_dat_r;
	logic [NS-1:0] s_cyc, s_stb, s_we, s_ack, s_err;
	wb_ic_pkg::addr_t [NS-1:0] s_adr;
	wb_ic_pkg::sel_t [NS-1:0] s_sel;
	wb_ic_pkg::data_t [NS-1:0] s_dat_w, s_dat_r;

	integer seed;
	// Slave storage and the independent prediction of it
	logic [31:0] mem [NS][256];
	logic [31:0] ref_mem [NS][256];
	// Request each master currently has on the bus
	logic [31:0] cur_adr [NM];
	logic cur_we [NM];
	logic [3:0] cur_sel [NM];
	logic [31:0] cur_dat [NM];
	// Slave side samples taken at the rising edge
	logic smp_req [NS];
	logic smp_we [NS];
	wb_ic_pkg::addr_t smp_adr [NS];
	wb_ic_pkg::sel_t smp_sel [NS];
	wb_ic_pkg::data_t smp_dat [NS];
	int wait_cnt [NS];
	// Contention tracking on slave 2
	logic contending;
	int last_par;
	logic both_busy;

	wb_interconnect_2x4 UUT (
		.clk(clk), .rstn(rstn),
		.m_cyc_i(m_cyc), .m_stb_i(m_stb), .m_we_i(m_we), .m_adr_i(m_adr),
		.m_sel_i(m_sel), .m_dat_w_i(m_dat_w), .m_dat_r_o(m_dat_r),
		.m_ack_o(m_ack), .m_err_o(m_err),
		.s_cyc_o(s_cyc), .s_stb_o(s_stb), .s_we_o(s_we), .s_adr_o(s_adr),
		.s_sel_o(s_sel), .s_dat_w_o(s_dat_w), .s_dat_r_i(s_dat_r),
		.s_ack_i(s_ack), .s_err_i(s_err)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_failed(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			stop_failed($sformatf("Fail %s expected %h actual %h", name, exp, act));
		end
	endtask

	function automatic int rand_below(input int n);
		return int'({$random(seed)} % n);
	endfunction

	// Pattern from the full byte address of the word
	function automatic logic [31:0] fill_word(input int s, input int w);
		logic [31:0] a;
		a = 32'(s * 4096 + w * 4);
		return (a * 32'h9E37_79B1) ^ 32'h0F0F_1234;
	endfunction

	// One classic cycle from master m, checked against the reference memory
	task automatic bus_cycle(input int m, input logic we, input logic [31:0] adr,
		input logic [3:0] sel, input logic [31:0] wdat);
		int cnt;
		int s;
		int w;
		logic got_ack;
		logic got_err;
		logic [31:0] rdat;
		s = (adr < 32'h4000) ? int'(adr[13:12]) : NS;
		w = int'(adr[9:2]);
		cnt = 0;
		got_ack = 1'b0;
		got_err = 1'b0;
		rdat = '0;
		@(negedge clk);
		cur_adr[m] = adr;
		cur_we[m] = we;
		cur_sel[m] = sel;
		cur_dat[m] = wdat;
		m_cyc[m] = 1'b1;
		m_stb[m] = 1'b1;
		m_we[m] = we;
		m_adr[m] = adr;
		m_sel[m] = sel;
		m_dat_w[m] = wdat;
		while (!got_ack && !got_err) begin
			@(posedge clk);
			got_ack = m_ack[m];
			got_err = m_err[m];
			rdat = m_dat_r[m];
			cnt++;
			if (cnt > 100) begin
				stop_failed($sformatf("Master %0d got no ack or err for address %h", m, adr));
			end
		end
		@(negedge clk);
		m_cyc[m] = 1'b0;
		m_stb[m] = 1'b0;
		// Response must have been a single pulse
		@(posedge clk);
		check_value("single response", 0, {m_ack[m], m_err[m]});
		if (s == NS) begin
			check_value("unmapped err", 2'b01, {got_ack, got_err});
		end else begin
			check_value("mapped ack", 2'b10, {got_ack, got_err});
			if (we) begin
				for (int b = 0; b < 4; b++) begin
					if (sel[b]) ref_mem[s][w][8*b +: 8] = wdat[8*b +: 8];
				end
			end else begin
				check_value("read data", ref_mem[s][w], rdat);
			end
		end
	endtask

	// Random cycles, slot 0..3 picks a window, 4 is unmapped, -1 draws one each time
	task automatic traffic(input int m, input int slot, input int n);
		int sl;
		int w;
		logic we;
		logic [31:0] adr;
		repeat (n) begin
			sl = (slot < 0) ? rand_below(NS + 1) : slot;
			// Master parity keeps the two masters on disjoint words
			w = 2 * rand_below(128) + m;
			adr = (sl == NS) ? 32'h0001_0000 + 32'(w * 4) : 32'(sl * 4096 + w * 4);
			we = 1'(rand_below(2));
			bus_cycle(m, we, adr, we ? 4'(rand_below(15) + 1) : 4'hF, $random(seed));
		end
	endtask

	task automatic serve_slave(input int s);
		int m;
		int w;
		m = int'(smp_adr[s][2]);
		w = int'(smp_adr[s][9:2]);
		if (s_ack[s]) begin
			// Ack lasts one cycle, master drops stb meanwhile
			s_ack[s] = 1'b0;
		end else if (smp_req[s]) begin
			check_value("slave window", s, smp_adr[s][31:12]);
			if (wait_cnt[s] < 0) wait_cnt[s] = rand_below(4);
			if (wait_cnt[s] == 0) begin
				check_value("slave adr", cur_adr[m], smp_adr[s]);
				check_value("slave we", cur_we[m], smp_we[s]);
				check_value("slave sel", cur_sel[m], smp_sel[s]);
				if (smp_we[s]) begin
					check_value("slave dat_w", cur_dat[m], smp_dat[s]);
					for (int b = 0; b < 4; b++) begin
						if (smp_sel[s][b]) mem[s][w][8*b +: 8] = smp_dat[s][8*b +: 8];
					end
				end
				s_dat_r[s] = mem[s][w];
				s_ack[s] = 1'b1;
				wait_cnt[s] = -1;
				if (contending && s == 2) begin
					if (last_par >= 0) check_value("round robin order", 1 - last_par, m);
					last_par = m;
				end
			end else begin
				wait_cnt[s]--;
			end
		end
	endtask

	// Slave models sample on the rising edge and answer on the falling edge
	always begin
		@(posedge clk);
		for (int s = 0; s < NS; s++) begin
			smp_req[s] = s_cyc[s] && s_stb[s];
			smp_adr[s] = s_adr[s];
			smp_we[s] = s_we[s];
			smp_sel[s] = s_sel[s];
			smp_dat[s] = s_dat_w[s];
		end
		if ($countones(s_cyc) > 1) both_busy = 1'b1;
		@(negedge clk);
		for (int s = 0; s < NS; s++) begin
			serve_slave(s);
		end
	end

	initial begin
		seed = 20036;
		rstn = 1'b0;
		m_cyc = '0;
		m_stb = '0;
		m_we = '0;
		m_adr = '0;
		m_sel = '0;
		m_dat_w = '0;
		s_dat_r = '0;
		s_ack = '0;
		s_err = '0;
		contending = 1'b0;
		last_par = -1;
		both_busy = 1'b0;
		for (int s = 0; s < NS; s++) begin
			wait_cnt[s] = -1;
			for (int w = 0; w < 256; w++) begin
				mem[s][w] = fill_word(s, w);
				ref_mem[s][w] = fill_word(s, w);
			end
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		@(posedge clk);
		check_value("idle after reset", 0, {s_cyc, s_stb, m_ack, m_err});
		// Directed write then read on each master, then unmapped
		bus_cycle(0, 1'b1, 32'h0000_1010, 4'hF, 32'hCAFE_0001);
		bus_cycle(0, 1'b0, 32'h0000_1010, 4'hF, '0);
		bus_cycle(1, 1'b1, 32'h0000_3024, 4'h6, 32'hBEEF_5A5A);
		bus_cycle(1, 1'b0, 32'h0000_3024, 4'hF, '0);
		bus_cycle(0, 1'b0, 32'h0000_8000, 4'hF, '0);
		bus_cycle(1, 1'b1, 32'h0001_0004, 4'hF, 32'h1234_5678);
		// Both masters hammer slave 2
		contending = 1'b1;
		// Lone master 0 cycle leaves the pointer on master 0 before the pairs
		traffic(0, 2, 1);
		// Pairs start together so only the pointer decides who goes first
		repeat (12) begin
			fork
				traffic(0, 2, 1);
				traffic(1, 2, 1);
			join
		end
		contending = 1'b0;
		// Disjoint slaves run side by side
		both_busy = 1'b0;
		fork
			traffic(0, 0, 8);
			traffic(1, 1, 8);
		join
		check_value("parallel slaves", 1, both_busy);
		fork
			traffic(0, -1, 150);
			traffic(1, -1, 150);
		join
		$display("Done: no errors");
		$finish;
	end

endmodule
